//--- tb.f
+incdir+tests
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_trap_regs.sv
hw/csr_counters.sv
hw/trap_request.sv
hw/csr_read_mux.sv
hw/csr_file.sv
tests/tb_csr_file.sv

//--- Bender.yml
package:
  name: csr_file

sources:
  - files:
      - hw/csr_pkg.sv
      - hw/csr_decode.sv
      - hw/csr_trap_regs.sv
      - hw/csr_counters.sv
      - hw/trap_request.sv
      - hw/csr_read_mux.sv
      - hw/csr_file.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_csr_file.sv

//--- tests/csr_model.svh
// --------------------
// Reference model of the machine-mode CSR state
// Register write rules and trap entry/exit
// --------------------
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Predicted state, raw storage form
logic [31:0] exp_mscratch;
logic [31:0] exp_mtvec;   // Base only, mode added on read
logic [31:0] exp_mepc;
logic [31:0] exp_mie;
logic [31:0] exp_mcause;  // Irq flag in 31, code in 4:0
logic        exp_mstatus_mie;
logic        exp_mstatus_mpie;

localparam logic [31:0] EXP_MISA = (32'd1 << 30) | (32'd1 << 8); // MXL 1, I only

// Every implemented address
logic [11:0] csr_list [17] = '{MVENDORID, MARCHID, MIMPID, MHARTID, MSTATUS, MISA, MIE,
	MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP, MCYCLE, MINSTRET, MCYCLEH, MINSTRETH};

task automatic clear_model();
	exp_mscratch     = '0;
	exp_mtvec        = '0;
	exp_mepc         = '0;
	exp_mie          = '0;
	exp_mcause       = '0;
	exp_mstatus_mie  = 1'b0;
	exp_mstatus_mpie = 1'b0;
endtask

// 0 write, 1 set, 2 clear
function automatic logic [31:0] apply_wtype(input logic [31:0] old_val,
		input logic [31:0] data, input logic [1:0] t);
	if (t == 2'd1)
		return old_val | data;
	else if (t == 2'd2)
		return old_val & ~data;
	return data;
endfunction

task automatic note_csr_write(input logic [11:0] a, input logic [31:0] d, input logic [1:0] t);
	logic [31:0] st;
	st = apply_wtype({24'b0, exp_mstatus_mpie, 3'b0, exp_mstatus_mie, 3'b0}, d, t);
	case (a)
		MSCRATCH: exp_mscratch = apply_wtype(exp_mscratch, d, t);
		MTVEC:    exp_mtvec    = apply_wtype(exp_mtvec, d, t) & 32'hffff_f000; // 4 KiB base
		MEPC:     exp_mepc     = apply_wtype(exp_mepc, d, t) & ~32'd1;
		MIE:      exp_mie      = apply_wtype(exp_mie, d, t) & 32'hffff_0888;
		MCAUSE:   exp_mcause   = apply_wtype(exp_mcause, d, t) & 32'h8000_001f;
		MSTATUS: begin
			exp_mstatus_mie  = st[3];
			exp_mstatus_mpie = st[7];
		end
		default: ; // Read-only or ignored
	endcase
endtask

// Non-counter registers only
function automatic logic [31:0] expected_read(input logic [11:0] a);
	case (a)
		MSTATUS:  return 32'h0000_1800 | (32'(exp_mstatus_mpie) << 7) | (32'(exp_mstatus_mie) << 3);
		MISA:     return EXP_MISA;
		MIE:      return exp_mie;
		MTVEC:    return exp_mtvec | 32'd1; // Vectored
		MSCRATCH: return exp_mscratch;
		MEPC:     return exp_mepc;
		MCAUSE:   return exp_mcause;
		default:  return 32'd0; // Identity, mtval, idle mip
	endcase
endfunction

task automatic note_trap_entry(input logic is_irq, input logic [4:0] code,
		input logic [31:0] epc);
	exp_mepc         = epc & ~32'd1;
	exp_mcause       = {is_irq, 26'b0, code};
	exp_mstatus_mpie = exp_mstatus_mie;
	exp_mstatus_mie  = 1'b0;
endtask

task automatic note_trap_exit();
	exp_mstatus_mie  = exp_mstatus_mpie;
	exp_mstatus_mpie = 1'b1;
endtask

// Exception inputs in port order, ecall is code 11
function automatic logic [4:0] first_exc_code(input logic [8:0] bits);
	int i;
	for (i = 0; i < 8; i++) begin
		if (bits[i])
			return 5'(i);
	end
	return 5'd11;
endfunction

function automatic int lowest_line(input logic [15:0] v);
	int i;
	for (i = 0; i < 16; i++) begin
		if (v[i])
			return i;
	end
	return 0;
endfunction

function automatic logic is_mapped(input logic [11:0] a);
	logic hit;
	hit = 1'b0;
	foreach (csr_list[i]) begin
		if (csr_list[i] == a)
			hit = 1'b1;
	end
	return hit;
endfunction

`endif

//--- tests/tb_csr_file.sv
// --------------------
// Testbench for the machine-mode CSR block
// Seeded random stimulus checked against a reference model
// --------------------
`timescale 1ns/1ps

module tb_csr_file;
	import csr_pkg::*;

	logic        clk;
	logic        rst_n;
	logic [11:0] addr;
	logic [31:0] wdata;
	logic        wen;
	logic        ren;
	csr_wtype_e  wtype;
	logic [31:0] rdata;
	logic [31:0] trap_addr;
	logic        trap_enter_vld;
	logic        trap_enter_rdy;
	logic        trap_exit;
	logic [31:0] mepc_in;
	logic [31:0] mepc_out;
	logic [15:0] irq;
	logic [8:0]  exc;       // Exception inputs, port order
	logic        instr_ret;

	integer seed;
	int     err_count;
	int     test_errs;   // Mismatches in the running test
	int     tests_run;
	int     tests_failed;
	int     checks;
	int     tb_cycles = 0; // Rising edges seen

	`include "csr_model.svh"

	csr_file uut (
		.clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata), .wen(wen), .ren(ren),
		.wtype(wtype), .rdata(rdata), .trap_addr(trap_addr), .trap_enter_vld(trap_enter_vld),
		.trap_enter_rdy(trap_enter_rdy), .trap_exit(trap_exit), .mepc_in(mepc_in),
		.mepc_out(mepc_out), .irq(irq),
		.except_instr_misaligned(exc[0]), .except_instr_fault(exc[1]),
		.except_instr_invalid(exc[2]), .except_breakpoint(exc[3]),
		.except_load_misaligned(exc[4]), .except_load_fault(exc[5]),
		.except_store_misaligned(exc[6]), .except_store_fault(exc[7]),
		.except_ecall(exc[8]), .instr_ret(instr_ret)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	always @(posedge clk) tb_cycles <= tb_cycles + 1;

	// --------------------
	// Helpers

	task automatic check_equal(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			err_count++;
			test_errs++;
			$display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %-12s %s (%0d mismatches)", name, test_errs == 0 ? "passed" : "failed",
			test_errs);
		test_errs = 0;
	endtask

	// Write lands at the second edge
	task automatic write_csr(input logic [11:0] a, input logic [31:0] d, input logic [1:0] t);
		@(posedge clk);
		addr  <= a;
		wdata <= d;
		wtype <= csr_wtype_e'(t);
		wen   <= 1'b1;
		ren   <= 1'b0;
		@(posedge clk);
		wen <= 1'b0;
		note_csr_write(a, d, t);
	endtask

	task automatic read_csr(input logic [11:0] a, output logic [31:0] d);
		@(posedge clk);
		addr <= a;
		wen  <= 1'b0;
		ren  <= 1'b1;
		@(negedge clk);
		d = rdata; // Combinational read
	endtask

	task automatic read_check(input logic [11:0] a, input string what);
		logic [31:0] d;
		read_csr(a, d);
		check_equal(what, d, expected_read(a));
	endtask

	task automatic wait_for_vld(input int max_cycles, output logic ok);
		int i;
		ok = 1'b0;
		for (i = 0; i < max_cycles && !ok; i++) begin
			@(negedge clk);
			if (trap_enter_vld)
				ok = 1'b1;
		end
		if (!ok) begin
			err_count++;
			test_errs++;
			$display("TIMEOUT at %0t: trap_enter_vld did not rise within %0d cycles", $time,
				max_cycles);
		end
	endtask

	task automatic pulse_trap_exit();
		@(posedge clk);
		trap_exit <= 1'b1;
		@(posedge clk);
		trap_exit <= 1'b0;
		note_trap_exit();
	endtask

	// --------------------
	// Tests

	task automatic test_reset();
		@(negedge clk);
		check_equal("vld after reset", trap_enter_vld, 1'b0);
		read_check(MSTATUS, "mstatus after reset");
		read_check(MTVEC, "mtvec after reset");
		read_check(MSCRATCH, "mscratch after reset");
		read_check(MCAUSE, "mcause after reset");
		end_test("reset");
	endtask

	task automatic test_reg_writes();
		logic [11:0] rw_list [5];
		logic [11:0] a;
		int          n;
		rw_list = '{MSCRATCH, MTVEC, MEPC, MIE, MCAUSE};
		for (n = 0; n < 40; n++) begin
			a = rw_list[$unsigned($random(seed)) % 5];
			write_csr(a, $random(seed), 2'($unsigned($random(seed)) % 3));
			read_check(a, $sformatf("readback of %h", a));
		end
		end_test("reg_writes");
	endtask

	task automatic test_fixed();
		logic [11:0] ro_list [7];
		int          n;
		ro_list = '{MISA, MVENDORID, MARCHID, MIMPID, MHARTID, MTVAL, MIP};
		for (n = 0; n < 7; n++)
			read_check(ro_list[n], $sformatf("fixed reg %h", ro_list[n]));
		// Write to a read-only identity register
		@(posedge clk);
		addr  <= MHARTID;
		wdata <= $random(seed);
		wtype <= WT_WRITE;
		wen   <= 1'b1;
		ren   <= 1'b0;
		@(negedge clk);
		check_equal("mhartid write vld", trap_enter_vld, 1'b1);
		check_equal("mhartid write trap_addr", trap_addr, exp_mtvec + 32'd4);
		@(posedge clk);
		wen <= 1'b0;
		@(negedge clk);
		check_equal("vld after mhartid write", trap_enter_vld, 1'b0);
		read_check(MHARTID, "mhartid after write");
		end_test("fixed");
	endtask

	task automatic test_unmapped();
		logic [11:0] a;
		logic [31:0] d;
		int          n;
		int          tries;
		for (n = 0; n < 8; n++) begin
			a = $random(seed);
			for (tries = 0; tries < 16 && is_mapped(a); tries++)
				a = $random(seed);
			read_csr(a, d);
			check_equal("unmapped read vld", trap_enter_vld, 1'b1);
			check_equal("unmapped read trap_addr", trap_addr, exp_mtvec | 32'd4);
			check_equal("unmapped read data", d, 32'd0);
			a = csr_list[$unsigned($random(seed)) % 17];
			read_csr(a, d);
			check_equal("mapped read vld", trap_enter_vld, 1'b0);
		end
		end_test("unmapped");
	endtask

	task automatic test_exceptions();
		logic       old_mie;
		logic       ok;
		logic [8:0] bits;
		logic [4:0] code;
		logic [31:0] epc;
		int         n;
		for (n = 0; n < 8; n++) begin
			old_mie = $random(seed);
			write_csr(MSTATUS, {28'b0, old_mie, 3'b0}, 2'd0);
			bits = $random(seed);
			if (bits == '0)
				bits = 9'h100;
			code = first_exc_code(bits);
			epc  = $random(seed);
			@(posedge clk);
			exc     <= bits;
			mepc_in <= epc;
			wait_for_vld(4, ok);
			check_equal("exception trap_addr", trap_addr, exp_mtvec | (32'(code) << 2));
			@(negedge clk); // Still held off by rdy low
			check_equal("exception vld held", trap_enter_vld, 1'b1);
			check_equal("exception trap_addr held", trap_addr, exp_mtvec | (32'(code) << 2));
			check_equal("mepc held", mepc_out, exp_mepc);
			@(posedge clk);
			trap_enter_rdy <= 1'b1;
			@(posedge clk);
			trap_enter_rdy <= 1'b0;
			exc            <= '0;
			note_trap_entry(1'b0, code, epc);
			@(negedge clk);
			check_equal("mepc_out after trap", mepc_out, exp_mepc);
			read_check(MCAUSE, "exception mcause");
			read_check(MSTATUS, "mstatus on trap entry");
			// Nested exception ignored while in trap
			@(posedge clk);
			exc <= 9'h001 | 9'($random(seed));
			@(negedge clk);
			check_equal("vld while in trap", trap_enter_vld, 1'b0);
			@(posedge clk);
			exc <= '0;
			pulse_trap_exit();
			read_check(MSTATUS, "mstatus after trap exit");
		end
		end_test("exceptions");
	endtask

	task automatic test_interrupts();
		logic [31:0] d;
		logic [31:0] epc;
		logic [15:0] lines;
		logic [15:0] en;
		logic        fire_exp;
		int          line;
		int          n;
		for (n = 0; n < 16; n++) begin
			d = $random(seed);
			if (($random(seed) & 3) != 0)
				d[11] = 1'b1; // MEIE on most of the time
			write_csr(MIE, d, 2'd0);
			write_csr(MSTATUS, {28'b0, (($random(seed) & 3) != 0), 3'b0}, 2'd0);
			lines    = $random(seed) & $random(seed);
			en       = lines & exp_mie[31:16] & {16{exp_mie[11]}};
			fire_exp = (en != '0) && exp_mstatus_mie;
			@(posedge clk);
			irq <= lines;
			@(negedge clk);
			check_equal("vld before irq sampled", trap_enter_vld, 1'b0);
			@(negedge clk);
			check_equal("irq vld", trap_enter_vld, fire_exp);
			if (fire_exp) begin
				line = lowest_line(en);
				check_equal("irq trap_addr", trap_addr, exp_mtvec | (32'(32 + line) << 2));
				epc = $random(seed);
				@(posedge clk);
				trap_enter_rdy <= 1'b1;
				mepc_in        <= epc;
				@(posedge clk);
				trap_enter_rdy <= 1'b0;
				irq            <= '0;
				note_trap_entry(1'b1, 5'(16 + line), epc);
				read_check(MCAUSE, "irq mcause");
				read_check(MSTATUS, "mstatus on irq entry");
				pulse_trap_exit();
			end else begin
				@(posedge clk);
				irq <= '0;
			end
		end
		end_test("interrupts");
	endtask

	task automatic test_counters();
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] d;
		logic [63:0] exp64;
		int          mark;
		int          count;
		int          n;
		lo = 32'hffff_fff0 | (32'($random(seed)) & 32'd7); // Carry within 16 cycles
		hi = $random(seed);
		write_csr(MCYCLE, 32'd0, 2'd0);
		write_csr(MCYCLEH, hi, 2'd0);
		write_csr(MCYCLE, lo, 2'd0);
		@(negedge clk);
		mark = tb_cycles;
		check_equal("mcycle right after write", rdata, lo);
		for (n = 0; n < 12; n++) begin
			read_csr(MCYCLE, d);
			exp64 = {hi, lo} + 64'(tb_cycles - mark);
			check_equal("mcycle", d, exp64[31:0]);
			read_csr(MCYCLEH, d);
			exp64 = {hi, lo} + 64'(tb_cycles - mark);
			check_equal("mcycleh", d, exp64[63:32]);
		end
		// minstret counts only retire cycles
		lo = 32'hffff_fff8 | (32'($random(seed)) & 32'd3);
		hi = $random(seed);
		write_csr(MINSTRETH, hi, 2'd0);
		write_csr(MINSTRET, lo, 2'd0);
		count = 0;
		for (n = 0; n < 20; n++) begin
			d = $random(seed);
			@(posedge clk);
			instr_ret <= d[0];
			count += d[0];
		end
		@(posedge clk);
		instr_ret <= 1'b0;
		exp64 = {hi, lo} + 64'(count);
		read_csr(MINSTRET, d);
		check_equal("minstret", d, exp64[31:0]);
		read_csr(MINSTRETH, d);
		check_equal("minstreth", d, exp64[63:32]);
		end_test("counters");
	endtask

	// --------------------
	// Main sequence

	initial begin
		seed           = 32'h8045_3216;
		err_count      = 0;
		test_errs      = 0;
		tests_run      = 0;
		tests_failed   = 0;
		checks         = 0;
		rst_n          = 1'b0;
		addr           = MSTATUS;
		wdata          = '0;
		wen            = 1'b0;
		ren            = 1'b0;
		wtype          = WT_WRITE;
		trap_enter_rdy = 1'b0;
		trap_exit      = 1'b0;
		mepc_in        = '0;
		irq            = '0;
		exc            = '0;
		instr_ret      = 1'b0;
		clear_model();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		test_reset();
		test_reg_writes();
		test_fixed();
		test_unmapped();
		test_exceptions();
		test_interrupts();
		test_counters();

		$display("%0d tests, %0d failed, %0d checks, %0d mismatches", tests_run, tests_failed,
			checks, err_count);
		if (err_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- hw/csr_file.sv
// --------------------
// Machine-mode CSR block top level
// --------------------
`timescale 1ns/1ps

module csr_file (
	input  logic                      clk,
	input  logic                      rst_n,
	// CSR access
	input  logic [11:0]               addr,
	input  logic [csr_pkg::XLEN-1:0]  wdata,
	input  logic                      wen,
	input  logic                      ren,
	input  csr_pkg::csr_wtype_e       wtype,
	output logic [csr_pkg::XLEN-1:0]  rdata,
	// Trap handshake
	output logic [csr_pkg::XLEN-1:0]  trap_addr,
	output logic                      trap_enter_vld,
	input  logic                      trap_enter_rdy,
	input  logic                      trap_exit,
	input  logic [csr_pkg::XLEN-1:0]  mepc_in,
	output logic [csr_pkg::XLEN-1:0]  mepc_out,
	// Interrupts and exceptions
	input  logic [csr_pkg::N_IRQ-1:0] irq,
	input  logic                      except_instr_misaligned,
	input  logic                      except_instr_fault,
	input  logic                      except_instr_invalid,
	input  logic                      except_breakpoint,
	input  logic                      except_load_misaligned,
	input  logic                      except_load_fault,
	input  logic                      except_store_misaligned,
	input  logic                      except_store_fault,
	input  logic                      except_ecall,
	input  logic                      instr_ret
);
	import csr_pkg::*;

	csr_sel_e          csr_sel;
	logic              wr_en, access_error;
	logic              mstatus_mie, mstatus_mpie;
	logic [XLEN-1:0]   mscratch, mtvec, mie, mip;
	logic              mcause_irq, cause_irq, trap_fire;
	logic [4:0]        mcause_code, cause_code;
	logic [2*XLEN-1:0] mcycle, minstret;

	csr_decode u_decode (
		.addr(addr), .wen(wen), .ren(ren), .wtype(wtype),
		.csr_sel(csr_sel), .wr_en(wr_en), .access_error(access_error)
	);

	csr_trap_regs u_trap_regs (
		.clk(clk), .rst_n(rst_n), .csr_sel(csr_sel), .wr_en(wr_en), .wtype(wtype),
		.wdata(wdata), .trap_fire(trap_fire), .trap_exit(trap_exit), .mepc_in(mepc_in),
		.cause_irq(cause_irq), .cause_code(cause_code),
		.mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie), .mscratch(mscratch),
		.mtvec(mtvec), .mepc(mepc_out), .mie(mie),
		.mcause_irq(mcause_irq), .mcause_code(mcause_code)
	);

	csr_counters u_counters (
		.clk(clk), .rst_n(rst_n), .csr_sel(csr_sel), .wr_en(wr_en), .wtype(wtype),
		.wdata(wdata), .instr_ret(instr_ret), .mcycle(mcycle), .minstret(minstret)
	);

	trap_request u_trap_request (
		.clk(clk), .rst_n(rst_n), .irq(irq),
		.except_instr_misaligned(except_instr_misaligned),
		.except_instr_fault(except_instr_fault),
		.except_instr_invalid(except_instr_invalid),
		.except_breakpoint(except_breakpoint),
		.except_load_misaligned(except_load_misaligned),
		.except_load_fault(except_load_fault),
		.except_store_misaligned(except_store_misaligned),
		.except_store_fault(except_store_fault),
		.except_ecall(except_ecall),
		.access_error(access_error), .mie(mie), .mstatus_mie(mstatus_mie), .mtvec(mtvec),
		.trap_enter_rdy(trap_enter_rdy), .trap_exit(trap_exit),
		.trap_enter_vld(trap_enter_vld), .trap_addr(trap_addr), .trap_fire(trap_fire),
		.cause_irq(cause_irq), .cause_code(cause_code), .mip(mip)
	);

	csr_read_mux u_read_mux (
		.csr_sel(csr_sel), .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie),
		.mscratch(mscratch), .mtvec(mtvec), .mepc(mepc_out), .mie(mie), .mip(mip),
		.mcause_irq(mcause_irq), .mcause_code(mcause_code),
		.mcycle(mcycle), .minstret(minstret), .rdata(rdata)
	);

endmodule

//--- hw/csr_read_mux.sv
// --------------------
// CSR read port, formats and selects read data
// --------------------
`timescale 1ns/1ps

module csr_read_mux (
	input  csr_pkg::csr_sel_e          csr_sel,
	input  logic                       mstatus_mie,
	input  logic                       mstatus_mpie,
	input  logic [csr_pkg::XLEN-1:0]   mscratch,
	input  logic [csr_pkg::XLEN-1:0]   mtvec,
	input  logic [csr_pkg::XLEN-1:0]   mepc,
	input  logic [csr_pkg::XLEN-1:0]   mie,
	input  logic [csr_pkg::XLEN-1:0]   mip,
	input  logic                       mcause_irq,
	input  logic [4:0]                 mcause_code,
	input  logic [2*csr_pkg::XLEN-1:0] mcycle,
	input  logic [2*csr_pkg::XLEN-1:0] minstret,
	output logic [csr_pkg::XLEN-1:0]   rdata
);
	import csr_pkg::*;

	always_comb begin
		rdata = '0; // Identity regs, mtval, unmapped
		case (csr_sel)
			SEL_MSTATUS:   rdata = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
			SEL_MISA:      rdata = MISA_VALUE;
			SEL_MIE:       rdata = mie;
			SEL_MTVEC:     rdata = {mtvec[XLEN-1:2], 2'b01}; // Vectored mode
			SEL_MSCRATCH:  rdata = mscratch;
			SEL_MEPC:      rdata = mepc;
			SEL_MCAUSE:    rdata = {mcause_irq, {(XLEN-6){1'b0}}, mcause_code};
			SEL_MIP:       rdata = mip;
			SEL_MCYCLE:    rdata = mcycle[XLEN-1:0];
			SEL_MINSTRET:  rdata = minstret[XLEN-1:0];
			SEL_MCYCLEH:   rdata = mcycle[2*XLEN-1:XLEN];
			SEL_MINSTRETH: rdata = minstret[2*XLEN-1:XLEN];
			default:       rdata = '0;
		endcase
	end

endmodule

//--- hw/trap_request.sv
// --------------------
// Trap request generator
// Exception/interrupt priority, vector address and cause
// --------------------
`timescale 1ns/1ps

module trap_request (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [csr_pkg::N_IRQ-1:0] irq,
	input  logic                      except_instr_misaligned,
	input  logic                      except_instr_fault,
	input  logic                      except_instr_invalid,
	input  logic                      except_breakpoint,
	input  logic                      except_load_misaligned,
	input  logic                      except_load_fault,
	input  logic                      except_store_misaligned,
	input  logic                      except_store_fault,
	input  logic                      except_ecall,
	input  logic                      access_error,
	input  logic [csr_pkg::XLEN-1:0]  mie,
	input  logic                      mstatus_mie,
	input  logic [csr_pkg::XLEN-1:0]  mtvec,
	input  logic                      trap_enter_rdy,
	input  logic                      trap_exit,
	output logic                      trap_enter_vld,
	output logic [csr_pkg::XLEN-1:0]  trap_addr,
	output logic                      trap_fire,
	output logic                      cause_irq,
	output logic [4:0]                cause_code,
	output logic [csr_pkg::XLEN-1:0]  mip
);
	import csr_pkg::*;

	logic [N_IRQ-1:0] irq_r;     // One-cycle sampled irq
	logic             in_trap;   // No exception nesting
	logic [15:0]      exc_vec;   // Indexed by exception code
	logic             exc_any;
	logic [3:0]       exc_num;
	logic [N_IRQ-1:0] irq_en;
	logic             irq_any;
	logic [3:0]       irq_num;
	logic [5:0]       vec_entry; // Up to 16 + 31

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r   <= '0;
			in_trap <= 1'b0;
		end else begin
			irq_r   <= irq;
			in_trap <= (in_trap || trap_fire) && !trap_exit;
		end
	end

	assign mip = {irq_r, 4'b0, |irq_r, 11'b0}; // MEIP summarises all lines

	// --------------------
	// Exceptions in standard code order
	always_comb begin
		exc_vec                  = '0;
		exc_vec[0]               = except_instr_misaligned;
		exc_vec[EXC_INSTR_FAULT] = except_instr_fault || access_error;
		exc_vec[2]               = except_instr_invalid;
		exc_vec[3]               = except_breakpoint;
		exc_vec[4]               = except_load_misaligned;
		exc_vec[5]               = except_load_fault;
		exc_vec[6]               = except_store_misaligned;
		exc_vec[7]               = except_store_fault;
		exc_vec[11]              = except_ecall; // M-mode ecall
	end

	assign exc_any = |exc_vec && !in_trap;
	assign exc_num = lowest_set(exc_vec);

	// Line enable, then MEIE, then global MIE
	assign irq_en  = irq_r & mie[31:16] & {N_IRQ{mie[11]}};
	assign irq_any = |irq_en && mstatus_mie;
	assign irq_num = lowest_set(irq_en);

	// --------------------
	assign trap_enter_vld = exc_any || irq_any;
	assign trap_fire      = trap_enter_vld && trap_enter_rdy;
	assign cause_irq      = !exc_any; // Exceptions always win
	assign cause_code     = exc_any ? {1'b0, exc_num} : 5'(IRQ_CODE_BASE) + {1'b0, irq_num};

	assign vec_entry = cause_irq ? 6'(IRQ_CODE_BASE) + {1'b0, cause_code} : {1'b0, cause_code};
	assign trap_addr = mtvec | {{(XLEN-8){1'b0}}, vec_entry, 2'b00}; // Entry ORed into base

	// Request held off by rdy keeps its address and cause while its sources hold
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(trap_enter_vld && !trap_enter_rdy && !trap_exit) && $stable(exc_vec)
			&& $stable(irq_r) && $stable(mie) && $stable(mstatus_mie) && $stable(mtvec)
		|-> trap_enter_vld && $stable(trap_addr) && $stable(cause_code))
		else $error("trap_request: held trap request changed");

endmodule

//--- hw/csr_counters.sv
// --------------------
// mcycle and minstret, 64 bits each
// --------------------
`timescale 1ns/1ps

module csr_counters (
	input  logic                       clk,
	input  logic                       rst_n,
	input  csr_pkg::csr_sel_e          csr_sel,
	input  logic                       wr_en,
	input  csr_pkg::csr_wtype_e        wtype,
	input  logic [csr_pkg::XLEN-1:0]   wdata,
	input  logic                       instr_ret,
	output logic [2*csr_pkg::XLEN-1:0] mcycle,
	output logic [2*csr_pkg::XLEN-1:0] minstret
);
	import csr_pkg::*;

	// Index 0 is mcycle, 1 is minstret
	logic [2*XLEN-1:0] cnt_q [2];
	logic [2*XLEN-1:0] cnt_d [2];
	logic [1:0]        cnt_inc;
	logic [1:0]        wr_lo;
	logic [1:0]        wr_hi;

	assign cnt_inc = {instr_ret, 1'b1};
	assign wr_lo   = {wr_en && csr_sel == SEL_MINSTRET, wr_en && csr_sel == SEL_MCYCLE};
	assign wr_hi   = {wr_en && csr_sel == SEL_MINSTRETH, wr_en && csr_sel == SEL_MCYCLEH};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			cnt_d[i] = cnt_q[i] + {{(2*XLEN-1){1'b0}}, cnt_inc[i]}; // Carry crosses halves
			if (wr_lo[i])
				cnt_d[i][XLEN-1:0] = csr_update(cnt_q[i][XLEN-1:0], wdata, wtype); // Write wins
			if (wr_hi[i])
				cnt_d[i][2*XLEN-1:XLEN] = csr_update(cnt_q[i][2*XLEN-1:XLEN], wdata, wtype);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q[0] <= '0;
			cnt_q[1] <= '0;
		end else begin
			cnt_q[0] <= cnt_d[0];
			cnt_q[1] <= cnt_d[1];
		end
	end

	assign mcycle   = cnt_q[0];
	assign minstret = cnt_q[1];

endmodule

//--- hw/csr_trap_regs.sv
// --------------------
// Trap setup and handling CSRs
// Software writes plus trap entry/exit updates
// --------------------
`timescale 1ns/1ps

module csr_trap_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_sel_e        csr_sel,
	input  logic                     wr_en,
	input  csr_pkg::csr_wtype_e      wtype,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  logic                     trap_fire,
	input  logic                     trap_exit,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	input  logic                     cause_irq,
	input  logic [4:0]               cause_code,
	output logic                     mstatus_mie,
	output logic                     mstatus_mpie,
	output logic [csr_pkg::XLEN-1:0] mscratch,
	output logic [csr_pkg::XLEN-1:0] mtvec,
	output logic [csr_pkg::XLEN-1:0] mepc,
	output logic [csr_pkg::XLEN-1:0] mie,
	output logic                     mcause_irq,
	output logic [4:0]               mcause_code
);
	import csr_pkg::*;

	logic [XLEN-1:0] mstatus_nxt; // Software result in CSR layout
	logic [XLEN-1:0] mcause_nxt;
	logic [XLEN-1:0] mepc_nxt;

	assign mstatus_nxt = csr_update({{(XLEN-8){1'b0}}, mstatus_mpie, 3'b0, mstatus_mie, 3'b0},
		wdata, wtype);
	assign mcause_nxt  = csr_update({mcause_irq, {(XLEN-6){1'b0}}, mcause_code}, wdata, wtype);
	assign mepc_nxt    = csr_update(mepc, wdata, wtype);

	// --------------------
	// Interrupt-enable stack

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (trap_fire) begin
			mstatus_mpie <= mstatus_mie; // Push
			mstatus_mie  <= 1'b0;
		end else if (trap_exit) begin
			mstatus_mie  <= mstatus_mpie; // Pop
			mstatus_mpie <= 1'b1;
		end else if (wr_en && csr_sel == SEL_MSTATUS) begin
			mstatus_mie  <= mstatus_nxt[3];
			mstatus_mpie <= mstatus_nxt[7];
		end
	end

	// Software-only registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch <= '0;
			mtvec    <= '0;
			mie      <= '0;
		end else if (wr_en) begin
			if (csr_sel == SEL_MSCRATCH)
				mscratch <= csr_update(mscratch, wdata, wtype);
			if (csr_sel == SEL_MTVEC)
				mtvec <= csr_update(mtvec, wdata, wtype) & MTVEC_MASK; // No adder for vectors
			if (csr_sel == SEL_MIE)
				mie <= csr_update(mie, wdata, wtype) & MIE_WRITABLE;
		end
	end

	// --------------------
	// Trap-captured state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc        <= '0;
			mcause_irq  <= 1'b0;
			mcause_code <= 5'd0;
		end else if (trap_fire) begin
			mepc        <= {mepc_in[XLEN-1:1], 1'b0};
			mcause_irq  <= cause_irq;
			mcause_code <= cause_code;
		end else if (wr_en) begin
			if (csr_sel == SEL_MEPC)
				mepc <= {mepc_nxt[XLEN-1:1], 1'b0}; // Bit 0 hardwired
			if (csr_sel == SEL_MCAUSE) begin
				mcause_irq  <= mcause_nxt[XLEN-1];
				mcause_code <= mcause_nxt[4:0];
			end
		end
	end

	// Core never retires mret in the cycle a trap is taken
	assert property (@(posedge clk) disable iff (!rst_n) !(trap_fire && trap_exit))
		else $error("csr_trap_regs: trap entry and exit in same cycle");

endmodule

//--- hw/csr_decode.sv
// --------------------
// CSR address decoder
// Register select, write enable and access-error flag
// --------------------
`timescale 1ns/1ps

module csr_decode (
	input  logic [11:0]         addr,
	input  logic                wen,
	input  logic                ren,
	input  csr_pkg::csr_wtype_e wtype,
	output csr_pkg::csr_sel_e   csr_sel,
	output logic                wr_en,
	output logic                access_error
);
	import csr_pkg::*;

	logic read_only;  // Identity registers
	logic wr_ignored; // Legal write, no effect

	always_comb begin
		csr_sel = SEL_NONE; // Anything unmapped
		case (addr)
			MVENDORID: csr_sel = SEL_MVENDORID;
			MARCHID:   csr_sel = SEL_MARCHID;
			MIMPID:    csr_sel = SEL_MIMPID;
			MHARTID:   csr_sel = SEL_MHARTID;
			MSTATUS:   csr_sel = SEL_MSTATUS;
			MISA:      csr_sel = SEL_MISA;
			MIE:       csr_sel = SEL_MIE;
			MTVEC:     csr_sel = SEL_MTVEC;
			MSCRATCH:  csr_sel = SEL_MSCRATCH;
			MEPC:      csr_sel = SEL_MEPC;
			MCAUSE:    csr_sel = SEL_MCAUSE;
			MTVAL:     csr_sel = SEL_MTVAL;
			MIP:       csr_sel = SEL_MIP;
			MCYCLE:    csr_sel = SEL_MCYCLE;
			MINSTRET:  csr_sel = SEL_MINSTRET;
			MCYCLEH:   csr_sel = SEL_MCYCLEH;
			MINSTRETH: csr_sel = SEL_MINSTRETH;
			default:   csr_sel = SEL_NONE;
		endcase
	end

	assign read_only  = csr_sel inside {SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID};
	assign wr_ignored = csr_sel inside {SEL_MISA, SEL_MTVAL, SEL_MIP}; // WARL tied

	assign wr_en = wen && (csr_sel != SEL_NONE) && !read_only && !wr_ignored;

	// Unmapped access, or write to an MRO register
	assign access_error = ((wen || ren) && (csr_sel == SEL_NONE)) || (wen && read_only);

	// Core only issues the three defined opcodes
	always_comb begin
		if (wen) begin
			assert final (wtype inside {WT_WRITE, WT_SET, WT_CLEAR})
				else $error("csr_decode: undefined write type %0d", wtype);
		end
	end

endmodule

//--- hw/csr_pkg.sv
// --------------------
// Machine-mode CSR definitions
// Widths, addresses, opcodes, masks and shared helpers
// --------------------
package csr_pkg;

	localparam int XLEN          = 32;
	localparam int N_IRQ         = 16; // External interrupt lines
	localparam int IRQ_CODE_BASE = 16; // mcause code of irq 0

	// Implemented CSR addresses
	typedef enum logic [11:0] {
		MVENDORID = 12'hf11,
		MARCHID   = 12'hf12,
		MIMPID    = 12'hf13,
		MHARTID   = 12'hf14,
		MSTATUS   = 12'h300,
		MISA      = 12'h301,
		MIE       = 12'h304,
		MTVEC     = 12'h305,
		MSCRATCH  = 12'h340,
		MEPC      = 12'h341,
		MCAUSE    = 12'h342,
		MTVAL     = 12'h343,
		MIP       = 12'h344,
		MCYCLE    = 12'hb00,
		MINSTRET  = 12'hb02,
		MCYCLEH   = 12'hb80,
		MINSTRETH = 12'hb82
	} csr_addr_e;

	typedef enum logic [1:0] {
		WT_WRITE = 2'd0,
		WT_SET   = 2'd1,
		WT_CLEAR = 2'd2
	} csr_wtype_e;

	// Decoded register target
	typedef enum logic [4:0] {
		SEL_NONE, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID,
		SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC,
		SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
		SEL_MCYCLE, SEL_MINSTRET, SEL_MCYCLEH, SEL_MINSTRETH
	} csr_sel_e;

	// RV32I only
	localparam logic [XLEN-1:0] MISA_VALUE   = {2'b01, 21'b0, 1'b1, 8'b0};
	localparam logic [XLEN-1:0] MTVEC_MASK   = {{(XLEN-12){1'b1}}, 12'b0}; // 4 KiB aligned
	localparam logic [XLEN-1:0] MIE_WRITABLE = 32'hffff_0888;             // Per-irq, MEIE, MTIE, MSIE

	localparam int EXC_INSTR_FAULT = 1;

	// Write, set or clear applied to the current value
	function automatic logic [XLEN-1:0] csr_update(input logic [XLEN-1:0] old_val,
			input logic [XLEN-1:0] wdata, input csr_wtype_e wtype);
		case (wtype)
			WT_SET:   csr_update = old_val | wdata;
			WT_CLEAR: csr_update = old_val & ~wdata;
			default:  csr_update = wdata;
		endcase
	endfunction

	// Index of lowest set bit, lowest index wins
	function automatic logic [3:0] lowest_set(input logic [15:0] vec);
		int i;
		lowest_set = 4'd0;
		for (i = 15; i >= 0; i--) begin
			if (vec[i])
				lowest_set = i[3:0];
		end
	endfunction

endpackage
